/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_flow_merge
RTL_TOP   ?= flow_merge_top
FLIST     ?= flow_merge_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flow_merge_top.f */
+incdir+rtl
rtl/merge_pkg.sv
rtl/flow_fifo.sv
rtl/flow_arb_lru.sv
rtl/flow_mux_lru.sv
rtl/merge_ctrl.sv
rtl/flow_merge_top.sv
sim/tb_clk_gen.sv
sim/tb_flow_merge.sv

/* rtl/flow_arb_lru.sv */
`timescale 1ns/100ps

module flow_arb_lru (
  input  logic                  clk,
  input  logic                  rst_n,
  // Requests from the flows
  input  merge_pkg::valid_vec_t push_valid,
  output merge_pkg::valid_vec_t push_ready,
  // Single granted output
  input  logic                  pop_ready,
  output logic                  pop_valid
);

  import merge_pkg::*;

  // --------------------------------------------------
  // Recency state
  // --------------------------------------------------

  // older[i][j] set when flow i was granted less recently than flow j
  // Diagonal bits stay zero
  logic [NUM_FLOWS-1:0][NUM_FLOWS-1:0] older;

  // Requesting flow with the oldest last grant
  valid_vec_t grant;

  logic pop_xfer;

  // --------------------------------------------------
  // Grant selection
  // --------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_FLOWS; i++) begin
      grant[i] = push_valid[i];
      // Lose to any requester that has waited longer
      for (int j = 0; j < NUM_FLOWS; j++) begin
        if ((j != i) && push_valid[j] && older[j][i]) begin
          grant[i] = 1'b0;
        end
      end
    end
  end

  // Any request makes the output valid
  assign pop_valid = |push_valid;

  // Onehot0 ready, only while the consumer is ready
  assign push_ready = grant & {NUM_FLOWS{pop_ready}};

  assign pop_xfer = pop_valid && pop_ready;

  // --------------------------------------------------
  // Order update
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Flow 0 oldest, then 1, 2, 3
      for (int i = 0; i < NUM_FLOWS; i++) begin
        for (int j = 0; j < NUM_FLOWS; j++) begin
          older[i][j] <= (i < j);
        end
      end
    end else if (pop_xfer) begin
      for (int i = 0; i < NUM_FLOWS; i++) begin
        if (grant[i]) begin
          // Winner becomes the most recent flow
          for (int j = 0; j < NUM_FLOWS; j++) begin
            if (j != i) begin
              older[i][j] <= 1'b0;
              older[j][i] <= 1'b1;
            end
          end
        end
      end
    end
  end

endmodule

/* rtl/flow_fifo.sv */
`timescale 1ns/100ps

module flow_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  // Write side
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  // Read side
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  // Pointer and occupancy widths, pointer kept at least one bit wide
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);

  // Storage array
  T mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  logic push;
  logic pop;

  // --------------------------------------------------
  // Handshakes
  // --------------------------------------------------

  // Not full, or full with a pop freeing a slot on this edge
  assign in_ready  = (count != FULL_CNT) || out_ready;
  // Head word is visible one cycle after it was written
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // Wrap explicitly so any depth works
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Count only moves when exactly one side transfers
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Payload write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

/* rtl/flow_merge_top.sv */
`timescale 1ns/100ps
`include "merge_config.svh"

module flow_merge_top (
  input  logic                                     clk,
  input  logic                                     rst_n,
  // Input flows
  input  merge_pkg::valid_vec_t                    in_valid,
  output merge_pkg::valid_vec_t                    in_ready,
  input  merge_pkg::data_t [`MERGE_NUM_FLOWS-1:0]  in_data,
  // Merged output
  output logic                                     out_valid,
  input  logic                                     out_ready,
  output merge_pkg::tagged_word_t                  out_word,
  // APB
  input  logic [`MERGE_APB_AW-1:0]                 paddr,
  input  logic                                     psel,
  input  logic                                     penable,
  input  logic                                     pwrite,
  input  logic [31:0]                              pwdata,
  output logic [31:0]                              prdata,
  output logic                                     pready,
  output logic                                     pslverr
);

  import merge_pkg::*;

  // Input FIFO heads toward the multiplexer
  valid_vec_t                push_valid;
  valid_vec_t                push_ready;
  data_t [NUM_FLOWS-1:0]     push_data;

  // Multiplexer toward the output FIFO
  logic         pop_valid;
  logic         pop_ready;
  tagged_word_t pop_word;

  // Control links
  logic       grant;
  flow_idx_t  grant_flow;
  valid_vec_t flow_enable;

  // --------------------------------------------------
  // Input buffers, one per flow
  // --------------------------------------------------

  for (genvar g = 0; g < NUM_FLOWS; g++) begin : g_in_fifo
    flow_fifo #(
      .T     (data_t),
      .DEPTH (`MERGE_IN_DEPTH)
    ) i_in_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid[g]),
      .in_ready  (in_ready[g]),
      .in_data   (in_data[g]),
      .out_valid (push_valid[g]),
      .out_ready (push_ready[g]),
      .out_data  (push_data[g])
    );
  end

  // --------------------------------------------------
  // LRU merge
  // --------------------------------------------------

  flow_mux_lru i_flow_mux_lru (
    .clk         (clk),
    .rst_n       (rst_n),
    .flow_enable (flow_enable),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .push_data   (push_data),
    .pop_ready   (pop_ready),
    .pop_valid   (pop_valid),
    .pop_word    (pop_word),
    .grant       (grant),
    .grant_flow  (grant_flow)
  );

  // Output buffer for tagged words
  flow_fifo #(
    .T     (tagged_word_t),
    .DEPTH (`MERGE_OUT_DEPTH)
  ) i_out_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (pop_valid),
    .in_ready  (pop_ready),
    .in_data   (pop_word),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_word)
  );

  // --------------------------------------------------
  // Register block
  // --------------------------------------------------

  merge_ctrl i_merge_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .grant       (grant),
    .grant_flow  (grant_flow),
    .flow_enable (flow_enable)
  );

endmodule

/* rtl/flow_mux_lru.sv */
`timescale 1ns/100ps
`include "merge_config.svh"

module flow_mux_lru (
  input  logic                                     clk,
  input  logic                                     rst_n,
  // Per-flow enable from the control block
  input  merge_pkg::valid_vec_t                    flow_enable,
  // Flow side
  input  merge_pkg::valid_vec_t                    push_valid,
  output merge_pkg::valid_vec_t                    push_ready,
  input  merge_pkg::data_t [`MERGE_NUM_FLOWS-1:0]  push_data,
  // Merged side
  input  logic                                     pop_ready,
  output logic                                     pop_valid,
  output merge_pkg::tagged_word_t                  pop_word,
  // Grant report for the counters
  output logic                                     grant,
  output merge_pkg::flow_idx_t                     grant_flow
);

  import merge_pkg::*;

  // Requests that survive the enable mask
  valid_vec_t req_valid;
  flow_idx_t  grant_idx;

  // Disabled flows never request, so their ready stays low
  assign req_valid = push_valid & flow_enable;

  flow_arb_lru i_flow_arb_lru (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (req_valid),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid)
  );

  // Index of the flow transferring now, ready is onehot0
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < NUM_FLOWS; i++) begin
      if (push_ready[i] && req_valid[i]) begin
        grant_idx = flow_idx_t'(i);
      end
    end
  end

  // Tag the selected word with its source
  assign pop_word = {grant_idx, push_data[grant_idx]};

  // One pulse per output transfer
  assign grant      = pop_valid && pop_ready;
  assign grant_flow = grant_idx;

endmodule

/* rtl/merge_config.svh */
`ifndef MERGE_CONFIG_SVH
`define MERGE_CONFIG_SVH

// --------------------------------------------------
// Flow merge build-time configuration
// --------------------------------------------------

// Number of input flows feeding the merger
`define MERGE_NUM_FLOWS 4

// Width of one payload word
`define MERGE_DATA_WIDTH 16

// Per-flow input buffer depth
`define MERGE_IN_DEPTH 4
// Output buffer depth
`define MERGE_OUT_DEPTH 4

// APB address bus width
`define MERGE_APB_AW 8
// Grant counter width, saturates at all ones
`define MERGE_CNT_WIDTH 16

`endif

/* rtl/merge_ctrl.sv */
`timescale 1ns/100ps
`include "merge_config.svh"

module merge_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,
  // APB slave
  input  logic [`MERGE_APB_AW-1:0]   paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  // Grant report from the multiplexer
  input  logic                       grant,
  input  merge_pkg::flow_idx_t       grant_flow,
  // Enable mask to the multiplexer
  output merge_pkg::valid_vec_t      flow_enable
);

  import merge_pkg::*;

  localparam int AW = `MERGE_APB_AW;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------

  localparam logic [AW-1:0] ADDR_ENABLE = AW'(8'h00);
  // COUNT0..COUNT3 sit at 0x04 + 4*n
  localparam logic [AW-1:0] ADDR_COUNT0 = AW'(8'h04);
  localparam logic [AW-1:0] ADDR_CLEAR  = AW'(8'h14);

  logic access;
  logic wr_en;
  logic rd_en;

  logic       hit_enable;
  logic       hit_clear;
  valid_vec_t hit_count;
  logic       addr_hit;

  valid_vec_t clr;
  valid_vec_t enable_q;
  cnt_t       cnt [NUM_FLOWS];

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------

  // No wait states, every access ends in its access phase
  assign access = psel && penable;
  assign wr_en  = access && pwrite;
  assign rd_en  = access && !pwrite;
  assign pready = 1'b1;

  assign hit_enable = (paddr == ADDR_ENABLE);
  assign hit_clear  = (paddr == ADDR_CLEAR);

  always_comb begin
    for (int i = 0; i < NUM_FLOWS; i++) begin
      hit_count[i] = (paddr == ADDR_COUNT0 + AW'(4 * i));
    end
  end

  assign addr_hit = hit_enable || hit_clear || (|hit_count);

  // Unmapped address flagged on the access phase only
  assign pslverr = access && !addr_hit;

  // Write-1 clear strobes, one per counter
  assign clr = (wr_en && hit_clear) ? pwdata[NUM_FLOWS-1:0] : '0;

  // --------------------------------------------------
  // Enable register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // All flows on out of reset
      enable_q <= '1;
    end else if (wr_en && hit_enable) begin
      enable_q <= pwdata[NUM_FLOWS-1:0];
    end
  end

  assign flow_enable = enable_q;

  // --------------------------------------------------
  // Grant counters
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_FLOWS; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_FLOWS; i++) begin
        // Clear beats a grant on the same edge
        if (clr[i]) begin
          cnt[i] <= '0;
        end else if (grant && (grant_flow == flow_idx_t'(i)) && (cnt[i] != '1)) begin
          // Saturate at all ones
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // Read data
  // --------------------------------------------------

  always_comb begin
    prdata = '0;
    if (rd_en) begin
      if (hit_enable) begin
        prdata = 32'(enable_q);
      end
      for (int i = 0; i < NUM_FLOWS; i++) begin
        if (hit_count[i]) begin
          prdata = 32'(cnt[i]);
        end
      end
      // CLEAR and unmapped addresses read as zero
    end
  end

endmodule

/* rtl/merge_pkg.sv */
`include "merge_config.svh"

package merge_pkg;

  // --------------------------------------------------
  // Derived sizes
  // --------------------------------------------------

  // Flow count as seen by the RTL
  localparam int NUM_FLOWS = `MERGE_NUM_FLOWS;
  // Bits needed to name one flow
  localparam int FLOW_IDX_W = $clog2(`MERGE_NUM_FLOWS);

  // --------------------------------------------------
  // Shared types
  // --------------------------------------------------

  // One payload word
  typedef logic [`MERGE_DATA_WIDTH-1:0] data_t;

  // Source flow number
  typedef logic [FLOW_IDX_W-1:0] flow_idx_t;

  // Output word, flow tag in the upper bits and payload below
  typedef logic [FLOW_IDX_W+`MERGE_DATA_WIDTH-1:0] tagged_word_t;

  // One bit per flow, used for valids, readies and the enable mask
  typedef logic [`MERGE_NUM_FLOWS-1:0] valid_vec_t;

  // Per-flow grant counter
  typedef logic [`MERGE_CNT_WIDTH-1:0] cnt_t;

endpackage

/* sim/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset held over the first rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* sim/tb_flow_merge.sv */
`timescale 1ns/100ps
`include "merge_config.svh"

module tb_flow_merge;

  import merge_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DW         = `MERGE_DATA_WIDTH;
  localparam int AW         = `MERGE_APB_AW;
  localparam int RAND_WORDS = 16;
  localparam int HOLD_WORDS = 12;
  // Total words pushed over the whole run
  localparam int TOTAL_WORDS = 8 * NUM_FLOWS + RAND_WORDS * NUM_FLOWS + HOLD_WORDS;

  // Register offsets
  localparam logic [AW-1:0] REG_ENABLE = AW'(8'h00);
  localparam logic [AW-1:0] REG_COUNT0 = AW'(8'h04);
  localparam logic [AW-1:0] REG_CLEAR  = AW'(8'h14);

  logic                  clk;
  logic                  rst_n;
  valid_vec_t            in_valid;
  valid_vec_t            in_ready;
  data_t [NUM_FLOWS-1:0] in_data;
  logic                  out_valid;
  logic                  out_ready;
  tagged_word_t          out_word;
  logic [AW-1:0]         paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;

  // --------------------------------------------------
  // Reference state
  // --------------------------------------------------

  // Per-flow words pushed and not yet seen at the output
  data_t      ref_q [NUM_FLOWS][$];
  // Recency list with the oldest grant first
  int         lru_order [NUM_FLOWS];
  int         out_count [NUM_FLOWS];
  int         next_seq [NUM_FLOWS];
  valid_vec_t enable_mask;
  bit         predict;
  bit         rand_run;
  int         push_total = 0;
  int         out_total = 0;
  int         errors = 0;
  int         seed;

  tb_clk_gen #(
    .PERIOD     (CLK_PERIOD),
    .RST_CYCLES (2)
  ) i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  flow_merge_top i_flow_merge_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_word  (out_word),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  // Flow number in the top nibble and sequence number below
  function automatic data_t make_word(input int flow, input int seq);
    return data_t'({4'(flow), 12'(seq)});
  endfunction

  // Oldest candidate in the recency list by the LRU rule, or -1 when none
  function automatic int lru_pick(input valid_vec_t cand);
    int pick;
    pick = -1;
    for (int k = NUM_FLOWS - 1; k >= 0; k--) begin
      if (cand[lru_order[k]]) begin
        pick = lru_order[k];
      end
    end
    return pick;
  endfunction

  // Granted flow moves to the most recent end
  function automatic void lru_touch(input int flow);
    int pos;
    pos = 0;
    for (int k = 0; k < NUM_FLOWS; k++) begin
      if (lru_order[k] == flow) begin
        pos = k;
      end
    end
    for (int k = pos; k < NUM_FLOWS - 1; k++) begin
      lru_order[k] = lru_order[k + 1];
    end
    lru_order[NUM_FLOWS - 1] = flow;
  endfunction

  // Enabled flows that still owe words
  function automatic valid_vec_t pending_mask();
    valid_vec_t m;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      m[f] = enable_mask[f] && (ref_q[f].size() != 0);
    end
    return m;
  endfunction

  task automatic check_output(input tagged_word_t w);
    flow_idx_t tag_f;
    int        tag;
    int        exp_flow;
    data_t     exp_data;
    tag_f    = w[DW +: FLOW_IDX_W];
    tag      = int'(tag_f);
    exp_flow = lru_pick(pending_mask());
    assert (enable_mask[tag]) else begin
      errors++;
      $display("Word from disabled flow %0d left the merger at %0t", tag, $time);
    end
    if (predict) begin
      assert (tag == exp_flow) else begin
        errors++;
        $display("ERR %0t out_word.flow expected %0d got %0d", $time, exp_flow, tag);
      end
    end
    assert (ref_q[tag].size() != 0) else begin
      errors++;
      $display("Extra word %h from flow %0d at %0t, nothing was pending", w, tag, $time);
    end
    if (ref_q[tag].size() != 0) begin
      exp_data = ref_q[tag].pop_front();
      assert (w[DW-1:0] == exp_data) else begin
        errors++;
        $display("ERR %0t out_word.data expected %h got %h", $time, exp_data, w[DW-1:0]);
      end
    end
    lru_touch(tag);
    out_count[tag]++;
    out_total++;
  endtask

  // --------------------------------------------------
  // Comparing process sampling both handshakes on the rising edge
  // --------------------------------------------------

  always @(posedge clk) begin
    if (rst_n) begin
      if (out_valid && out_ready) begin
        check_output(out_word);
      end
      for (int f = 0; f < NUM_FLOWS; f++) begin
        if (in_valid[f] && in_ready[f]) begin
          ref_q[f].push_back(in_data[f]);
          push_total++;
        end
      end
    end
  end

  // Producer for one flow with optional random gaps between words
  task automatic push_words(input int flow, input int n, input bit gaps);
    int sent;
    bit xfer;
    sent = 0;
    xfer = 1'b0;
    while (sent < n) begin
      @(negedge clk);
      if (xfer) begin
        in_valid[flow] = 1'b0;
      end
      if (!in_valid[flow] && (!gaps || (($random(seed) & 1) == 1))) begin
        in_data[flow]  = make_word(flow, next_seq[flow]);
        in_valid[flow] = 1'b1;
      end
      @(posedge clk);
      xfer = in_valid[flow] && in_ready[flow];
      if (xfer) begin
        sent++;
        next_seq[flow]++;
      end
    end
    @(negedge clk);
    in_valid[flow] = 1'b0;
  endtask

  // --------------------------------------------------
  // APB access with a setup phase and then an access phase
  // --------------------------------------------------

  task automatic apb_xfer(input logic write, input logic [AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    rdata = prdata;
    err   = pslverr;
    // No wait states, so the access ends on this edge
    assert (pready) else begin
      errors++;
      $display("ERR %0t pready at %h expected 1 got %0b", $time, addr, pready);
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [AW-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, data, rdata, err);
    assert (err == exp_err) else begin
      errors++;
      $display("ERR %0t pslverr at %h expected %0b got %0b", $time, addr, exp_err, err);
    end
  endtask

  task automatic check_reg(input logic [AW-1:0] addr, input logic [31:0] exp,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, 32'h0, rdata, err);
    assert (err == exp_err) else begin
      errors++;
      $display("ERR %0t pslverr at %h expected %0b got %0b", $time, addr, exp_err, err);
    end
    assert (rdata == exp) else begin
      errors++;
      $display("ERR %0t prdata at %h expected %h got %h", $time, addr, exp, rdata);
    end
  endtask

  task automatic set_enable(input valid_vec_t mask);
    write_reg(REG_ENABLE, 32'(mask), 1'b0);
    enable_mask = mask;
  endtask

  task automatic clear_counts(input valid_vec_t mask);
    write_reg(REG_CLEAR, 32'(mask), 1'b0);
    for (int f = 0; f < NUM_FLOWS; f++) begin
      if (mask[f]) begin
        out_count[f] = 0;
      end
    end
  endtask

  task automatic check_counts();
    for (int f = 0; f < NUM_FLOWS; f++) begin
      check_reg(AW'(REG_COUNT0 + 4 * f), 32'(out_count[f]), 1'b0);
    end
  endtask

  // Wait until all but the held words have left
  task automatic drain(input int held);
    wait (out_total == push_total - held);
    repeat (2) @(negedge clk);
  endtask

  task automatic wait_ready_low(input int flow, input int limit);
    int n;
    n = 0;
    while (in_ready[flow] && (n < limit)) begin
      @(negedge clk);
      n++;
    end
    assert (!in_ready[flow]) else begin
      errors++;
      $display("in_ready of flow %0d never fell while out_ready was low", flow);
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin
    seed        = 1;
    in_valid    = '0;
    in_data     = '0;
    out_ready   = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    enable_mask = '1;
    predict     = 1'b0;
    rand_run    = 1'b0;
    for (int f = 0; f < NUM_FLOWS; f++) begin
      lru_order[f] = f;
      out_count[f] = 0;
      next_seq[f]  = 0;
    end
    @(posedge rst_n);

    // Fill every buffer behind a stalled output and then release it
    fork
      push_words(0, 5, 1'b0);
      push_words(1, 5, 1'b0);
      push_words(2, 5, 1'b0);
      push_words(3, 5, 1'b0);
    join
    assert (in_ready == '0) else begin
      errors++;
      $display("ERR %0t in_ready expected 0 got %b", $time, in_ready);
    end
    predict   = 1'b1;
    out_ready = 1'b1;
    drain(0);
    predict = 1'b0;
    check_counts();
    clear_counts('1);
    check_counts();

    // Flow 1 masked off while its words wait in its buffer
    set_enable(4'b1101);
    out_ready = 1'b0;
    fork
      push_words(0, 3, 1'b0);
      push_words(1, 3, 1'b0);
      push_words(2, 3, 1'b0);
      push_words(3, 3, 1'b0);
    join
    predict   = 1'b1;
    out_ready = 1'b1;
    drain(3);
    set_enable('1);
    drain(0);
    predict = 1'b0;

    // Random producers against a random consumer
    rand_run = 1'b1;
    fork
      begin
        fork
          push_words(0, RAND_WORDS, 1'b1);
          push_words(1, RAND_WORDS, 1'b1);
          push_words(2, RAND_WORDS, 1'b1);
          push_words(3, RAND_WORDS, 1'b1);
        join
        rand_run = 1'b0;
      end
      begin
        while (rand_run) begin
          @(negedge clk);
          out_ready = 1'($random(seed));
        end
      end
    join

    // A single producer sees in_ready fall behind a stalled output
    out_ready = 1'b0;
    fork
      push_words(2, HOLD_WORDS, 1'b0);
      begin
        wait_ready_low(2, 4 * (`MERGE_IN_DEPTH + `MERGE_OUT_DEPTH));
        out_ready = 1'b1;
      end
    join
    drain(0);

    // Counter reads with a partial clear and unmapped accesses
    check_counts();
    clear_counts(4'b0101);
    check_counts();
    check_reg(REG_CLEAR, 32'h0, 1'b0);
    // Data would clear counters 1 and 3 or change the mask if decoded
    write_reg(AW'(8'h18), 32'hA, 1'b1);
    check_reg(AW'(8'h18), 32'h0, 1'b1);
    write_reg(AW'(8'h02), 32'hA, 1'b1);
    check_reg(REG_ENABLE, 32'hF, 1'b0);
    check_counts();

    for (int f = 0; f < NUM_FLOWS; f++) begin
      assert (ref_q[f].size() == 0) else begin
        errors++;
        $display("%0d words of flow %0d never left the merger", ref_q[f].size(), f);
      end
    end

    $display("Run complete: %0d errors, %0d words in, %0d words out",
             errors, push_total, out_total);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog allowing 1.5 x 10 cycles per pushed word
  initial begin
    #(TOTAL_WORDS * 15 * CLK_PERIOD);
    $display("Watchdog expired at %0t, the run hung", $time);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
